// ==== div_pkg.sv ====
package div_pkg;

    localparam int XLEN        = 32;
    localparam int DIV_STEPS   = XLEN;          // one quotient bit per step
    localparam int DIV_LATENCY = DIV_STEPS + 1; // steps plus result register

    // per-operation tag carried alongside the data
    localparam int TAG_W       = 3;
    localparam int TAG_NEG_Q   = 0; // negate quotient
    localparam int TAG_NEG_R   = 1; // negate remainder
    localparam int TAG_REM_SEL = 2; // return remainder

    typedef logic [XLEN-1:0]  xlen_t;
    typedef logic [XLEN:0]    prem_t; // one bit wider than divisor
    typedef logic [TAG_W-1:0] div_tag_t;

endpackage

// ==== div_cell.sv ====
`timescale 1ns/1ns

module div_cell (
    input  logic           clk,
    input  logic           rstn,
    input  logic           en,
    input  div_pkg::prem_t prem_in,
    input  div_pkg::xlen_t divisor_in,
    input  div_pkg::xlen_t quot_in,
    input  div_pkg::xlen_t dvd_in,
    output logic           rdy,
    output div_pkg::xlen_t rem_out,
    output div_pkg::xlen_t divisor_out,
    output div_pkg::xlen_t quot_out,
    output div_pkg::xlen_t dvd_out
);
    import div_pkg::*;

    prem_t divisor_ext;
    prem_t diff;
    logic  q_bit;

    assign divisor_ext = {1'b0, divisor_in};
    assign q_bit       = (prem_in >= divisor_ext);
    assign diff        = prem_in - divisor_ext;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdy <= 1'b0;
        end else begin
            rdy <= en;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rem_out     <= '0;
            divisor_out <= '0;
            quot_out    <= '0;
            dvd_out     <= '0;
        end else if (en) begin
            // restoring step: keep the difference only if it did not borrow
            rem_out     <= q_bit ? diff[XLEN-1:0] : prem_in[XLEN-1:0];
            divisor_out <= divisor_in;
            quot_out    <= {quot_in[XLEN-2:0], q_bit};
            dvd_out     <= {dvd_in[XLEN-2:0], 1'b0}; // top bit consumed here
        end
    end

    a_rdy_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown(rdy));

endmodule

// ==== div_operand_prep.sv ====
`timescale 1ns/1ns

module div_operand_prep (
    input  div_pkg::xlen_t    dividend,
    input  div_pkg::xlen_t    divisor,
    input  logic              div_sign,
    input  logic              rem_sel,
    output div_pkg::xlen_t    abs_dividend,
    output div_pkg::xlen_t    abs_divisor,
    output div_pkg::div_tag_t tag
);
    import div_pkg::*;

    logic dvd_neg;
    logic dsr_neg;
    logic dsr_zero;

    assign dvd_neg  = div_sign & dividend[XLEN-1];
    assign dsr_neg  = div_sign & divisor[XLEN-1];
    assign dsr_zero = (divisor == '0);

    assign abs_dividend = dvd_neg ? (~dividend + 1'b1) : dividend;
    assign abs_divisor  = dsr_neg ? (~divisor + 1'b1) : divisor;

    // x/0 must stay all ones, so no quotient sign fix there
    // remainder of x/0 is |x| and takes the dividend sign as usual
    always_comb begin
        tag              = '0;
        tag[TAG_NEG_Q]   = (dvd_neg ^ dsr_neg) & ~dsr_zero;
        tag[TAG_NEG_R]   = dvd_neg;
        tag[TAG_REM_SEL] = rem_sel;
    end

endmodule

// ==== div_pipe.sv ====
`timescale 1ns/1ns

module div_pipe (
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    input  div_pkg::xlen_t    abs_dividend,
    input  div_pkg::xlen_t    abs_divisor,
    input  div_pkg::div_tag_t in_tag,
    output logic              pipe_valid,
    output div_pkg::xlen_t    quotient,
    output div_pkg::xlen_t    remainder,
    output div_pkg::div_tag_t pipe_tag
);
    import div_pkg::*;

    logic [DIV_STEPS-1:0] rdy;
    xlen_t                rem   [DIV_STEPS];
    xlen_t                dsr   [DIV_STEPS];
    xlen_t                quot  [DIV_STEPS];
    xlen_t                dvd   [DIV_STEPS];
    div_tag_t             tag_q [DIV_STEPS];

    for (genvar i = 0; i < DIV_STEPS; i++) begin : g_step
        logic     en_s;
        prem_t    prem_s;
        xlen_t    dsr_s;
        xlen_t    quot_s;
        xlen_t    dvd_s;
        div_tag_t tag_s;

        if (i == 0) begin : g_first
            assign en_s   = in_valid;
            assign prem_s = {{XLEN{1'b0}}, abs_dividend[XLEN-1]};
            assign dsr_s  = abs_divisor;
            assign quot_s = '0;
            assign dvd_s  = abs_dividend;
            assign tag_s  = in_tag;
        end else begin : g_next
            assign en_s   = rdy[i-1];
            assign prem_s = {rem[i-1], dvd[i-1][XLEN-1]}; // bring down next bit
            assign dsr_s  = dsr[i-1];
            assign quot_s = quot[i-1];
            assign dvd_s  = dvd[i-1];
            assign tag_s  = tag_q[i-1];
        end

        div_cell u_cell (
            .clk         (clk),
            .rstn        (rstn),
            .en          (en_s),
            .prem_in     (prem_s),
            .divisor_in  (dsr_s),
            .quot_in     (quot_s),
            .dvd_in      (dvd_s),
            .rdy         (rdy[i]),
            .rem_out     (rem[i]),
            .divisor_out (dsr[i]),
            .quot_out    (quot[i]),
            .dvd_out     (dvd[i])
        );

        // tag follows its operation step by step
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                tag_q[i] <= '0;
            end else if (en_s) begin
                tag_q[i] <= tag_s;
            end
        end
    end

    assign pipe_valid = rdy[DIV_STEPS-1];
    assign quotient   = quot[DIV_STEPS-1];
    assign remainder  = rem[DIV_STEPS-1];
    assign pipe_tag   = tag_q[DIV_STEPS-1];

    a_valid_latency: assert property (@(posedge clk) disable iff (!rstn)
        in_valid |-> ##DIV_STEPS pipe_valid);

    a_no_spurious: assert property (@(posedge clk) disable iff (!rstn)
        pipe_valid |-> $past(in_valid, DIV_STEPS));

endmodule

// ==== div_result.sv ====
`timescale 1ns/1ns

module div_result (
    input  logic              clk,
    input  logic              rstn,
    input  logic              pipe_valid,
    input  div_pkg::xlen_t    quotient,
    input  div_pkg::xlen_t    remainder,
    input  div_pkg::div_tag_t pipe_tag,
    output logic              res_rdy,
    output div_pkg::xlen_t    div_res
);
    import div_pkg::*;

    xlen_t quot_fix;
    xlen_t rem_fix;
    xlen_t res_sel;

    assign quot_fix = pipe_tag[TAG_NEG_Q] ? (~quotient + 1'b1) : quotient;
    assign rem_fix  = pipe_tag[TAG_NEG_R] ? (~remainder + 1'b1) : remainder;
    assign res_sel  = pipe_tag[TAG_REM_SEL] ? rem_fix : quot_fix;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_rdy <= 1'b0;
            div_res <= '0;
        end else begin
            res_rdy <= pipe_valid; // one cycle pulse per operation
            if (pipe_valid) begin
                div_res <= res_sel;
            end
        end
    end

    a_res_known: assert property (@(posedge clk) disable iff (!rstn)
        res_rdy |-> !$isunknown(div_res));

endmodule

// ==== div_unit.sv ====
`timescale 1ns/1ns

module div_unit (
    input  logic           clk,
    input  logic           rstn,
    input  logic           div_valid,
    input  div_pkg::xlen_t dividend,
    input  div_pkg::xlen_t divisor,
    input  logic           div_sign, // 0 unsigned
    input  logic           rem_sel,  // 0 quotient
    output logic           res_rdy,
    output div_pkg::xlen_t div_res
);
    import div_pkg::*;

    xlen_t    abs_dividend;
    xlen_t    abs_divisor;
    div_tag_t tag;
    logic     pipe_valid;
    xlen_t    quotient;
    xlen_t    remainder;
    div_tag_t pipe_tag;

    div_operand_prep u_prep (
        .dividend     (dividend),
        .divisor      (divisor),
        .div_sign     (div_sign),
        .rem_sel      (rem_sel),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .tag          (tag)
    );

    div_pipe u_pipe (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (div_valid),
        .abs_dividend (abs_dividend),
        .abs_divisor  (abs_divisor),
        .in_tag       (tag),
        .pipe_valid   (pipe_valid),
        .quotient     (quotient),
        .remainder    (remainder),
        .pipe_tag     (pipe_tag)
    );

    div_result u_result (
        .clk        (clk),
        .rstn       (rstn),
        .pipe_valid (pipe_valid),
        .quotient   (quotient),
        .remainder  (remainder),
        .pipe_tag   (pipe_tag),
        .res_rdy    (res_rdy),
        .div_res    (div_res)
    );

endmodule

// ==== tb_div_unit.sv ====
`timescale 1ns/1ns

module tb_div_unit;
    import div_pkg::*;

    localparam int RST_CYCLES  = 16;
    localparam int IDLE_CYCLES = 4;
    localparam int TAIL_CYCLES = 10;
    localparam int N_DIRECTED  = 37;
    localparam int N_RANDOM    = 200;
    localparam int N_OPS       = N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + N_OPS + DIV_LATENCY + 50;

    typedef struct packed {
        xlen_t dividend;
        xlen_t divisor;
        logic  sgn;
        logic  sel;
        xlen_t expected;
    } vec_t;

    logic  clk;
    logic  rstn;
    logic  div_valid;
    xlen_t dividend;
    xlen_t divisor;
    logic  div_sign;
    logic  rem_sel;
    logic  res_rdy;
    xlen_t div_res;

    xlen_t       exp_q[$];    // expected results in launch order
    int          launch_q[$]; // cycle of each strobe
    int          cycle     = 0;
    int          n_checked = 0;
    logic [31:0] seed;

    vec_t dir_tab [N_DIRECTED] = '{
        // dividend      divisor        sign  sel   expected
        '{32'h0000_0064, 32'h0000_0007, 1'b0, 1'b0, 32'h0000_000e}, // divu
        '{32'h0000_0064, 32'h0000_0007, 1'b0, 1'b1, 32'h0000_0002}, // remu
        '{32'h0000_0005, 32'h0000_0009, 1'b0, 1'b0, 32'h0000_0000}, // divisor larger
        '{32'h0000_0005, 32'h0000_0009, 1'b0, 1'b1, 32'h0000_0005},
        '{32'hffff_ffff, 32'h0000_0010, 1'b0, 1'b0, 32'h0fff_ffff},
        '{32'hffff_ffff, 32'h0000_0010, 1'b0, 1'b1, 32'h0000_000f},
        '{32'h0000_0064, 32'h0000_0007, 1'b1, 1'b0, 32'h0000_000e}, // div, + / +
        '{32'hffff_ff9c, 32'h0000_0007, 1'b1, 1'b0, 32'hffff_fff2}, // - / +
        '{32'h0000_0064, 32'hffff_fff9, 1'b1, 1'b0, 32'hffff_fff2}, // + / -
        '{32'hffff_ff9c, 32'hffff_fff9, 1'b1, 1'b0, 32'h0000_000e}, // - / -
        '{32'h0000_0064, 32'h0000_0007, 1'b1, 1'b1, 32'h0000_0002}, // rem, + / +
        '{32'hffff_ff9c, 32'h0000_0007, 1'b1, 1'b1, 32'hffff_fffe},
        '{32'h0000_0064, 32'hffff_fff9, 1'b1, 1'b1, 32'h0000_0002},
        '{32'hffff_ff9c, 32'hffff_fff9, 1'b1, 1'b1, 32'hffff_fffe},
        '{32'h0000_04d2, 32'h0000_0000, 1'b0, 1'b0, 32'hffff_ffff}, // divu by zero
        '{32'h0000_04d2, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_04d2},
        '{32'hffff_fffb, 32'h0000_0000, 1'b1, 1'b0, 32'hffff_ffff}, // div by zero
        '{32'hffff_fffb, 32'h0000_0000, 1'b1, 1'b1, 32'hffff_fffb},
        '{32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b0, 32'h8000_0000}, // signed overflow
        '{32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1, 32'h0000_0000},
        '{32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0, 32'h0000_0000}, // same bits unsigned
        '{32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b1, 32'h8000_0000},
        '{32'h0000_0000, 32'h0000_0005, 1'b0, 1'b0, 32'h0000_0000},
        '{32'h0000_0000, 32'h0000_0005, 1'b0, 1'b1, 32'h0000_0000},
        '{32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0, 32'hffff_ffff},
        '{32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b1, 32'h0000_0000},
        '{32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0, 32'h0000_0001},
        '{32'h0000_0007, 32'h0000_0002, 1'b1, 1'b0, 32'h0000_0003},
        '{32'hffff_fff9, 32'h0000_0002, 1'b1, 1'b0, 32'hffff_fffd}, // truncates to -3
        '{32'hffff_fff9, 32'h0000_0002, 1'b1, 1'b1, 32'hffff_ffff},
        '{32'h0000_0007, 32'hffff_fffe, 1'b1, 1'b1, 32'h0000_0001},
        '{32'h0000_0007, 32'hffff_fffe, 1'b1, 1'b0, 32'hffff_fffd},
        '{32'h1234_5678, 32'h0000_0100, 1'b0, 1'b0, 32'h0012_3456},
        '{32'h1234_5678, 32'h0000_0100, 1'b0, 1'b1, 32'h0000_0078},
        '{32'h7fff_ffff, 32'hffff_ffff, 1'b1, 1'b0, 32'h8000_0001},
        '{32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0, 32'hffff_ffff}, // 0 / 0
        '{32'h0000_0000, 32'h0000_0000, 1'b1, 1'b1, 32'h0000_0000}
    };

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    div_unit u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .div_valid (div_valid),
        .dividend  (dividend),
        .divisor   (divisor),
        .div_sign  (div_sign),
        .rem_sel   (rem_sel),
        .res_rdy   (res_rdy),
        .div_res   (div_res)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RISC-V division rules, truncating toward zero
    function automatic xlen_t model_divide(input xlen_t a, input xlen_t b,
                                           input logic sgn, input logic sel);
        xlen_t  q;
        xlen_t  r;
        longint sa;
        longint sb;
        sa = sgn ? longint'($signed(a)) : longint'(a);
        sb = sgn ? longint'($signed(b)) : longint'(b);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = 32'h8000_0000;
            r = '0;
        end else begin
            q = xlen_t'(sa / sb);
            r = xlen_t'(sa % sb); // takes the dividend sign
        end
        return sel ? r : q;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_res(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h (result %0d)",
                     name, got, exp, n_checked);
            $display(">>> FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h (result %0d)",
                     name, got, exp, n_checked);
            $display(">>> FAIL");
            $fatal(1, "latency mismatch");
        end
    endtask

    // directed rows must agree with the rules as well
    task automatic check_table();
        vec_t v;
        for (int i = 0; i < N_DIRECTED; i++) begin
            v = dir_tab[i];
            if (model_divide(v.dividend, v.divisor, v.sgn, v.sel) !== v.expected) begin
                abort_run($sformatf("table entry %0d disagrees with the division rules", i));
            end
        end
    endtask

    task automatic launch_op(input xlen_t a, input xlen_t b, input logic sgn,
                             input logic sel, input xlen_t exp);
        @(posedge clk);
        div_valid <= 1'b1;
        dividend  <= a;
        divisor   <= b;
        div_sign  <= sgn;
        rem_sel   <= sel;
        exp_q.push_back(exp);
        launch_q.push_back(cycle);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the results did not all come back in time");
        end
    end

    always @(posedge clk) begin
        if (res_rdy === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("res_rdy pulsed with no operation outstanding");
            end else begin
                check_res("div_res", div_res, exp_q.pop_front());
                // res_rdy rose one edge before it is seen here
                check_latency("res_rdy latency", cycle - launch_q.pop_front() - 1,
                              DIV_LATENCY);
                n_checked++;
            end
        end else if (res_rdy !== 1'b0 && cycle > 0) begin
            abort_run("res_rdy is unknown");
        end
    end

    initial begin
        vec_t  v;
        xlen_t a;
        xlen_t b;
        logic  sgn;
        logic  sel;
        rstn      = 1'b0;
        div_valid = 1'b0;
        dividend  = '0;
        divisor   = '0;
        div_sign  = 1'b0;
        rem_sel   = 1'b0;
        seed      = 32'hb0fecfa9;
        check_table();

        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk); // idle, no pulse expected

        for (int i = 0; i < N_DIRECTED; i++) begin
            v = dir_tab[i];
            launch_op(v.dividend, v.divisor, v.sgn, v.sel, v.expected);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            seed = next_rand(seed);
            a    = seed;
            seed = next_rand(seed);
            b    = seed;
            seed = next_rand(seed);
            sgn  = seed[31];
            sel  = seed[30];
            case (seed[29:27])
                3'd0: b = '0;
                3'd1: begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end
                3'd2, 3'd3: b = b & 32'h0000_ffff; // long quotients
                3'd4: a = a & 32'h0000_00ff;       // mostly below divisor
                default: ;
            endcase
            launch_op(a, b, sgn, sel, model_divide(a, b, sgn, sel));
        end

        @(posedge clk);
        div_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (TAIL_CYCLES) @(posedge clk); // idle again after the drain

        if (exp_q.size() != 0 || n_checked != N_OPS) begin
            abort_run($sformatf("only %0d of %0d results came back", n_checked, N_OPS));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== div_unit.f ====
div_pkg.sv
div_cell.sv
div_operand_prep.sv
div_pipe.sv
div_result.sv
div_unit.sv
tb_div_unit.sv

// ==== Makefile ====
TOP = tb_div_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f div_unit.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
